//--- logic/dd_video_pkg.sv
// ########################################
// Video package
// Screen position, layer pixel and colour
// types plus sync and palette constants
// ########################################

package dd_video_pkg;

    // Palette of 32 entries
    localparam int PAL_AW = 5;

    // Horizontal sync placement after the active area, in pixels
    localparam int HS_START = 8;
    localparam int HS_LEN   = 8;

    typedef struct packed {
        logic [8:0] h;
        logic [8:0] v;
    } vpos_t;

    typedef struct packed {
        logic [3:0] color;
    } layer_pxl_t;

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

endpackage

//--- logic/dd_rom_pkg.sv
// ########################################
// ROM package
// Address widths and response types of the
// character and scroll graphics ROMs
// ########################################

package dd_rom_pkg;

    localparam int CHAR_AW = 15;
    localparam int SCR_AW  = 14;

    typedef struct packed {
        logic       ok;
        logic [7:0] data;
    } char_rsp_t;

    // Four 4bpp pixels per word
    typedef struct packed {
        logic        ok;
        logic [15:0] data;
    } scr_rsp_t;

endpackage

//--- logic/dd_cen.sv
// ########################################
// Clock enable generator
// 12 MHz and 6 MHz strobes from 48 MHz
// ########################################

`timescale 1ns/10ps

module dd_cen (
    input  logic clk,
    input  logic rst_n,
    output logic pxl2_cen,
    output logic pxl_cen
);

    logic [2:0] cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt      <= 3'd0;
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
        end else begin
            cnt      <= cnt + 3'd1;
            // Both strobes coincide at the end of the 8-clock period
            pxl2_cen <= (cnt[1:0] == 2'd3);
            pxl_cen  <= (cnt == 3'd7);
        end
    end

endmodule

//--- logic/dd_vtimer.sv
// ########################################
// Video timer
// Pixel and line counters with blanking
// and sync registered from the counts
// ########################################

`timescale 1ns/10ps

module dd_vtimer
    import dd_video_pkg::*;
#(
    parameter int H_ACTIVE = 256,
    parameter int H_TOTAL  = 384,
    parameter int V_ACTIVE = 240,
    parameter int V_TOTAL  = 272
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  pxl_cen,
    output vpos_t pos,
    output logic  HBL,
    output logic  VBL,
    output logic  HS,
    output logic  VS
);

    localparam logic [8:0] H_LAST = 9'(H_TOTAL - 1);
    localparam logic [8:0] V_LAST = 9'(V_TOTAL - 1);
    localparam logic [8:0] H_ACT  = 9'(H_ACTIVE);
    localparam logic [8:0] V_ACT  = 9'(V_ACTIVE);
    localparam logic [8:0] HS_ON  = 9'(H_ACTIVE + HS_START);
    localparam logic [8:0] HS_OFF = 9'(H_ACTIVE + HS_START + HS_LEN);
    localparam logic [8:0] VS_ON  = 9'(V_ACTIVE + 2);
    localparam logic [8:0] VS_END = 9'(V_ACTIVE + 3);

    logic [8:0] h_nxt;
    logic [8:0] v_nxt;

    always_comb begin
        h_nxt = pos.h + 9'd1;
        v_nxt = pos.v;
        if (pos.h == H_LAST) begin
            h_nxt = 9'd0;
            v_nxt = (pos.v == V_LAST) ? 9'd0 : pos.v + 9'd1;
        end
    end

    // Flags come from the next counts so they line up with pos
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pos <= '0;
            HBL <= 1'b0;
            VBL <= 1'b0;
            HS  <= 1'b0;
            VS  <= 1'b0;
        end else if (pxl_cen) begin
            pos.h <= h_nxt;
            pos.v <= v_nxt;
            HBL   <= (h_nxt >= H_ACT);
            VBL   <= (v_nxt >= V_ACT);
            HS    <= (h_nxt >= HS_ON) && (h_nxt < HS_OFF);
            VS    <= (v_nxt == VS_ON) || (v_nxt == VS_END);
        end
    end

endmodule

//--- logic/dd_char_layer.sv
// ########################################
// Character layer
// One 4bpp ROM byte fetch per pixel, nibble
// picked by the pixel column parity
// ########################################

`timescale 1ns/10ps

module dd_char_layer
    import dd_video_pkg::*;
    import dd_rom_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               pxl_cen,
    input  vpos_t              pos,
    output logic [CHAR_AW-1:0] char_addr,
    input  char_rsp_t          char_rsp,
    output layer_pxl_t         pxl
);

    logic [7:0] data;
    logic       odd;
    logic       armed;
    logic       pending;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            char_addr <= '0;
            odd       <= 1'b0;
            armed     <= 1'b0;
            pending   <= 1'b0;
        end else if (pxl_cen) begin
            char_addr <= {pos.v[7:0], pos.h[7:1]};
            odd       <= pos.h[0];
            armed     <= 1'b1;
            pending   <= 1'b0;
        end else if (armed) begin
            // ok may still belong to the previous address here
            armed   <= 1'b0;
            pending <= 1'b1;
        end else if (pending && char_rsp.ok) begin
            pending <= 1'b0;
        end
    end

    // Without ok the last byte stays in place
    always_ff @(posedge clk) begin
        if (pending && char_rsp.ok && !pxl_cen) data <= char_rsp.data;
    end

    assign pxl.color = odd ? data[3:0] : data[7:4];

endmodule

//--- logic/dd_scroll_layer.sv
// ########################################
// Scroll layer
// Offset coordinates, 16-bit ROM words of
// four 4bpp pixels, first pixel on top
// ########################################

`timescale 1ns/10ps

module dd_scroll_layer
    import dd_video_pkg::*;
    import dd_rom_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              pxl_cen,
    input  vpos_t             pos,
    input  logic [8:0]        scrhpos,
    input  logic [8:0]        scrvpos,
    output logic [SCR_AW-1:0] scr_addr,
    input  scr_rsp_t          scr_rsp,
    output layer_pxl_t        pxl
);

    logic [8:0]  hsum;
    logic [8:0]  vsum;
    logic [15:0] data;
    logic [1:0]  col;
    logic        armed;
    logic        pending;

    // Only the low 8 bits of each offset position matter
    assign hsum = pos.h + scrhpos;
    assign vsum = pos.v + scrvpos;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scr_addr <= '0;
            col      <= 2'd0;
            armed    <= 1'b0;
            pending  <= 1'b0;
        end else if (pxl_cen) begin
            scr_addr <= {vsum[7:0], hsum[7:2]};
            col      <= hsum[1:0];
            armed    <= 1'b1;
            pending  <= 1'b0;
        end else if (armed) begin
            armed   <= 1'b0;
            pending <= 1'b1;
        end else if (pending && scr_rsp.ok) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pending && scr_rsp.ok && !pxl_cen) data <= scr_rsp.data;
    end

    always_comb begin
        case (col)
            2'd0:    pxl.color = data[15:12];
            2'd1:    pxl.color = data[11:8];
            2'd2:    pxl.color = data[7:4];
            default: pxl.color = data[3:0];
        endcase
    end

endmodule

//--- logic/dd_colmix.sv
// ########################################
// Colour mixer
// Layer priority, palette RAM lookup and
// blanking aligned with the pixel
// ########################################

`timescale 1ns/10ps

module dd_colmix
    import dd_video_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              pxl_cen,
    input  layer_pxl_t        char_pxl,
    input  layer_pxl_t        scr_pxl,
    input  logic              HBL,
    input  logic              VBL,
    input  logic              pal_we,
    input  logic [PAL_AW-1:0] pal_addr,
    input  logic [11:0]       pal_data,
    output logic              LHBL_dly,
    output logic              LVBL_dly,
    output rgb_t              rgb
);

    rgb_t              pal_mem [0:(1<<PAL_AW)-1];
    logic [PAL_AW-1:0] pal_rd;
    logic              lhbl_s1;
    logic              lvbl_s1;

    // Red sits in the top nibble, same order as rgb_t
    always_ff @(posedge clk) begin
        if (pal_we) pal_mem[pal_addr] <= rgb_t'(pal_data);
    end

    // Character layer wins when its colour is not transparent
    always_comb begin
        if (char_pxl.color != 4'd0) pal_rd = {1'b1, char_pxl.color};
        else                        pal_rd = {1'b0, scr_pxl.color};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lhbl_s1  <= 1'b0;
            lvbl_s1  <= 1'b0;
            LHBL_dly <= 1'b0;
            LVBL_dly <= 1'b0;
            rgb      <= '0;
        end else if (pxl_cen) begin
            lhbl_s1  <= ~HBL;
            lvbl_s1  <= ~VBL;
            LHBL_dly <= lhbl_s1;
            LVBL_dly <= lvbl_s1;
            // Blank with the stage that becomes LxBL_dly at this edge
            rgb      <= (lhbl_s1 && lvbl_s1) ? pal_mem[pal_rd] : '0;
        end
    end

endmodule

//--- logic/dd_game.sv
// ########################################
// Video subsystem top level
// Enables, timer, char and scroll layers
// and the colour mixer
// ########################################

`timescale 1ns/10ps

module dd_game
    import dd_video_pkg::*;
    import dd_rom_pkg::*;
#(
    parameter int H_ACTIVE = 256,
    parameter int H_TOTAL  = 384,
    parameter int V_ACTIVE = 240,
    parameter int V_TOTAL  = 272
) (
    input  logic               clk,
    input  logic               rst_n,
    output logic               pxl2_cen,
    output logic               pxl_cen,
    output logic               HS,
    output logic               VS,
    output logic               LHBL_dly,
    output logic               LVBL_dly,
    // Scroll position
    input  logic [8:0]         scrhpos,
    input  logic [8:0]         scrvpos,
    // Graphics ROMs
    output logic [CHAR_AW-1:0] char_addr,
    input  char_rsp_t          char_rsp,
    output logic [SCR_AW-1:0]  scr_addr,
    input  scr_rsp_t           scr_rsp,
    // Palette writes
    input  logic               pal_we,
    input  logic [PAL_AW-1:0]  pal_addr,
    input  logic [11:0]        pal_data,
    output logic [3:0]         red,
    output logic [3:0]         green,
    output logic [3:0]         blue
);

    vpos_t      pos;
    logic       HBL;
    logic       VBL;
    layer_pxl_t char_pxl;
    layer_pxl_t scr_pxl;
    rgb_t       rgb;

    dd_cen u_cen (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pxl2_cen ( pxl2_cen ),
        .pxl_cen  ( pxl_cen  )
    );

    dd_vtimer #(
        .H_ACTIVE ( H_ACTIVE ),
        .H_TOTAL  ( H_TOTAL  ),
        .V_ACTIVE ( V_ACTIVE ),
        .V_TOTAL  ( V_TOTAL  )
    ) u_timer (
        .clk     ( clk     ),
        .rst_n   ( rst_n   ),
        .pxl_cen ( pxl_cen ),
        .pos     ( pos     ),
        .HBL     ( HBL     ),
        .VBL     ( VBL     ),
        .HS      ( HS      ),
        .VS      ( VS      )
    );

    dd_char_layer u_char (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .pxl_cen   ( pxl_cen   ),
        .pos       ( pos       ),
        .char_addr ( char_addr ),
        .char_rsp  ( char_rsp  ),
        .pxl       ( char_pxl  )
    );

    dd_scroll_layer u_scroll (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pxl_cen  ( pxl_cen  ),
        .pos      ( pos      ),
        .scrhpos  ( scrhpos  ),
        .scrvpos  ( scrvpos  ),
        .scr_addr ( scr_addr ),
        .scr_rsp  ( scr_rsp  ),
        .pxl      ( scr_pxl  )
    );

    dd_colmix u_colmix (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pxl_cen  ( pxl_cen  ),
        .char_pxl ( char_pxl ),
        .scr_pxl  ( scr_pxl  ),
        .HBL      ( HBL      ),
        .VBL      ( VBL      ),
        .pal_we   ( pal_we   ),
        .pal_addr ( pal_addr ),
        .pal_data ( pal_data ),
        .LHBL_dly ( LHBL_dly ),
        .LVBL_dly ( LVBL_dly ),
        .rgb      ( rgb      )
    );

    assign red   = rgb.red;
    assign green = rgb.green;
    assign blue  = rgb.blue;

endmodule

//--- bench/dd_game_checker.sv
// ########################################
// Video subsystem checker
// Enable pairing, blanking and sync rules
// ########################################

`timescale 1ns/10ps

module dd_game_checker (
    input logic       clk,
    input logic       rst_n,
    input logic       pxl_cen,
    input logic       pxl2_cen,
    input logic       HS,
    input logic       LHBL_dly,
    input logic       LVBL_dly,
    input logic [3:0] red,
    input logic [3:0] green,
    input logic [3:0] blue
);

    int fail_cnt = 0;

    a_cen_pair: assert property (@(posedge clk) disable iff (!rst_n) pxl_cen |-> pxl2_cen)
        else begin
            fail_cnt++;
            $error("pxl_cen high without pxl2_cen");
        end

    // Colour must be black outside the active area
    a_blank: assert property (@(posedge clk) disable iff (!rst_n)
        (!LHBL_dly || !LVBL_dly) |-> ({red, green, blue} == 12'h0))
        else begin
            fail_cnt++;
            $error("colour not zero during blanking");
        end

    a_hs_blank: assert property (@(posedge clk) disable iff (!rst_n) HS |-> !LHBL_dly)
        else begin
            fail_cnt++;
            $error("HS high outside horizontal blanking");
        end

endmodule

bind dd_game dd_game_checker i_checker (.*);

//--- bench/dd_game_tb.sv
// ########################################
// Video subsystem testbench
// Directed tests with ROM models and a
// pixel reference built from the rules
// ########################################

`timescale 1ns/10ps

module dd_game_tb
    import dd_video_pkg::*;
    import dd_rom_pkg::*;
();

    localparam int H_ACTIVE = 16;
    localparam int H_TOTAL  = 24;
    localparam int V_ACTIVE = 8;
    localparam int V_TOTAL  = 12;

    logic               clk;
    logic               rst_n;
    logic               pxl2_cen, pxl_cen, HS, VS, LHBL_dly, LVBL_dly;
    logic [8:0]         scrhpos;
    logic [8:0]         scrvpos;
    logic [CHAR_AW-1:0] char_addr;
    char_rsp_t          char_rsp;
    logic [SCR_AW-1:0]  scr_addr;
    scr_rsp_t           scr_rsp;
    logic               pal_we;
    logic [PAL_AW-1:0]  pal_addr;
    logic [11:0]        pal_data;
    logic [3:0]         red, green, blue;

    logic [15:0]        scr_tab [0:(1<<SCR_AW)-1];
    logic [11:0]        pal_val [0:31];
    logic [7:0]         char_mask;
    logic [CHAR_AW-1:0] char_last;
    logic [SCR_AW-1:0]  scr_last;
    int                 char_wait, scr_wait;
    int                 h, v, errors, timeouts;
    logic               lhbl_q, lvbl_q, frame_start;

    dd_game #(
        .H_ACTIVE ( H_ACTIVE ),
        .H_TOTAL  ( H_TOTAL  ),
        .V_ACTIVE ( V_ACTIVE ),
        .V_TOTAL  ( V_TOTAL  )
    ) i_dut (.*);

    always #10 clk = ~clk;

    // ROMs answer an address change with ok two clocks later
    always @(negedge clk) begin
        if (char_addr != char_last) begin
            char_last = char_addr;
            char_wait = 2;
        end else if (char_wait > 0) begin
            char_wait = char_wait - 1;
        end
        char_rsp.ok   = (char_wait == 0);
        char_rsp.data = char_last[7:0] & char_mask;
        if (scr_addr != scr_last) begin
            scr_last = scr_addr;
            scr_wait = 2;
        end else if (scr_wait > 0) begin
            scr_wait = scr_wait - 1;
        end
        scr_rsp.ok   = (scr_wait == 0);
        scr_rsp.data = scr_tab[scr_last];
    end

    // x^17 + x^14 + 1
    function automatic logic [16:0] lfsr_step(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    task automatic fill_scroll_rom();
        logic [16:0] s;
        logic [15:0] w;
        s = 17'd94657;
        for (int a = 0; a < (1 << SCR_AW); a++) begin
            for (int b = 0; b < 16; b++) begin
                s = lfsr_step(s);
                w = {w[14:0], s[0]};
            end
            scr_tab[a] = w;
        end
    endtask

    function automatic logic [11:0] expected_rgb(input int ph, input int pv);
        logic [CHAR_AW-1:0] caddr;
        logic [7:0]         cbyte;
        logic [3:0]         cnib;
        logic [7:0]         sh;
        logic [7:0]         sv;
        logic [3:0]         snib;
        caddr = {8'(pv), 7'(ph >> 1)};
        cbyte = caddr[7:0] & char_mask;
        cnib  = ph[0] ? cbyte[3:0] : cbyte[7:4];
        sh    = 8'(ph + scrhpos);
        sv    = 8'(pv + scrvpos);
        // First pixel of a word sits in the top nibble
        snib  = 4'(scr_tab[{sv, sh[7:2]}] >> (4 * (3 - sh[1:0])));
        return (cnib != 4'd0) ? pal_val[16 + cnib] : pal_val[snib];
    endfunction

    // Sync pixels that fall inside one line
    function automatic int hs_per_line();
        int n;
        n = 0;
        for (int x = 0; x < H_TOTAL; x++) begin
            if (x >= H_ACTIVE + HS_START && x < H_ACTIVE + HS_START + HS_LEN) n++;
        end
        return n;
    endfunction

    task automatic report();
        $display("errors: %0d, assertion failures: %0d, timeouts: %0d",
                 errors, i_dut.i_checker.fail_cnt, timeouts);
        if (errors == 0 && timeouts == 0 && i_dut.i_checker.fail_cnt == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    endtask

    // Step to the next pixel enable and follow the output position
    task automatic next_pixel();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!pxl_cen && n < 16);
        if (!pxl_cen) begin
            timeouts++;
            $display("timeout: no pixel enable within 16 clocks");
            report();
        end else begin
            frame_start = LVBL_dly && !lvbl_q;
            if (LHBL_dly && !lhbl_q) begin
                h = 0;
                v = frame_start ? 0 : v + 1;
            end else begin
                h++;
            end
            lhbl_q = LHBL_dly;
            lvbl_q = LVBL_dly;
        end
    endtask

    task automatic wait_frame_start();
        int n;
        n = 0;
        do begin
            next_pixel();
            n++;
        end while (!frame_start && n < 2 * H_TOTAL * V_TOTAL);
        if (!frame_start) begin
            timeouts++;
            $display("timeout: no frame start within two frames");
            report();
        end
    endtask

    task automatic check_frame(input string name);
        logic [11:0] exp_rgb;
        // One whole frame passes so new settings reach every stage
        wait_frame_start();
        wait_frame_start();
        for (int i = 0; i < H_TOTAL * V_ACTIVE; i++) begin
            if (i > 0) next_pixel();
            exp_rgb = expected_rgb(h, v);
            if (LHBL_dly && LVBL_dly && {red, green, blue} !== exp_rgb) begin
                errors++;
                $display("error: %s rgb at h=%0d v=%0d is %h, expected %h",
                         name, h, v, {red, green, blue}, exp_rgb);
            end
        end
    endtask

    task automatic check_idle();
        if ({pxl2_cen, pxl_cen, HS, VS, LHBL_dly, LVBL_dly} !== 6'h0) begin
            errors++;
            $display("error: {pxl2_cen,pxl_cen,HS,VS,LHBL_dly,LVBL_dly} is %h, expected 00",
                     {pxl2_cen, pxl_cen, HS, VS, LHBL_dly, LVBL_dly});
        end
        if ({red, green, blue} !== 12'h0) begin
            errors++;
            $display("error: rgb is %h, expected 000", {red, green, blue});
        end
    endtask

    task automatic test_reset();
        repeat (8) begin
            @(negedge clk);
            check_idle();
        end
        rst_n = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_idle();
        end
    endtask

    // Clocks 1 to 3 after release were seen by the reset test
    task automatic test_enables();
        for (int n = 4; n < 68; n++) begin
            @(negedge clk);
            if (pxl2_cen !== (n % 4 == 0)) begin
                errors++;
                $display("error: pxl2_cen is %h at clock %0d after reset", pxl2_cen, n);
            end
            if (pxl_cen !== (n % 8 == 0)) begin
                errors++;
                $display("error: pxl_cen is %h at clock %0d after reset", pxl_cen, n);
            end
        end
    endtask

    task automatic test_geometry();
        int   lines;
        int   vs_rises;
        int   hs_high;
        int   run;
        logic vs_q;
        wait_frame_start();
        lines    = 0;
        vs_rises = 0;
        hs_high  = 0;
        run      = 0;
        vs_q     = VS;
        for (int i = 0; i < H_TOTAL * V_TOTAL; i++) begin
            if (i > 0) next_pixel();
            if (LHBL_dly) begin
                run++;
            end else if (run != 0) begin
                if (run != H_ACTIVE) begin
                    errors++;
                    $display("error: LHBL_dly high for %0h enables, expected %0h", run, H_ACTIVE);
                end
                run = 0;
            end
            if (LHBL_dly && LVBL_dly && h == 0) lines++;
            if (VS && !vs_q) vs_rises++;
            vs_q = VS;
            if (HS) hs_high++;
        end
        if (lines != V_ACTIVE) begin
            errors++;
            $display("error: LVBL_dly active lines %0h, expected %0h", lines, V_ACTIVE);
        end
        if (vs_rises != 1) begin
            errors++;
            $display("error: VS rising edges per frame %0h, expected 1", vs_rises);
        end
        if (hs_high != V_TOTAL * hs_per_line()) begin
            errors++;
            $display("error: HS high for %0h enables per frame, expected %0h",
                     hs_high, V_TOTAL * hs_per_line());
        end
    endtask

    task automatic test_palette_scroll();
        char_mask = 8'h00;
        for (int i = 0; i < 32; i++) begin
            @(negedge clk);
            pal_we   = 1'b1;
            pal_addr = PAL_AW'(i);
            pal_data = pal_val[i];
        end
        @(negedge clk);
        pal_we = 1'b0;
        check_frame("palette");
    endtask

    task automatic test_priority();
        char_mask = 8'hff;
        check_frame("priority");
    endtask

    task automatic test_offsets();
        scrhpos = 9'd5;
        scrvpos = 9'd3;
        check_frame("scroll offset");
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        scrhpos     = '0;
        scrvpos     = '0;
        pal_we      = 1'b0;
        pal_addr    = '0;
        pal_data    = '0;
        char_rsp    = '0;
        scr_rsp     = '0;
        char_mask   = '0;
        char_last   = '1;
        scr_last    = '1;
        char_wait   = 0;
        scr_wait    = 0;
        errors      = 0;
        timeouts    = 0;
        h           = 0;
        v           = 0;
        // Start high so a line already in progress is not taken as a start
        lhbl_q      = 1'b1;
        lvbl_q      = 1'b1;
        frame_start = 1'b0;
        // Odd step keeps all 32 colours distinct
        for (int i = 0; i < 32; i++) pal_val[i] = 12'(i * 12'h13b + 12'h2a5);
        fill_scroll_rom();
        test_reset();
        test_enables();
        test_geometry();
        test_palette_scroll();
        test_priority();
        test_offsets();
        report();
    end

endmodule

//--- filelist.f
logic/dd_video_pkg.sv
logic/dd_rom_pkg.sv
logic/dd_cen.sv
logic/dd_vtimer.sv
logic/dd_char_layer.sv
logic/dd_scroll_layer.sv
logic/dd_colmix.sv
logic/dd_game.sv
bench/dd_game_checker.sv
bench/dd_game_tb.sv

//--- Bender.yml
package:
  name: dd_video

sources:
  - logic/dd_video_pkg.sv
  - logic/dd_rom_pkg.sv
  - logic/dd_cen.sv
  - logic/dd_vtimer.sv
  - logic/dd_char_layer.sv
  - logic/dd_scroll_layer.sv
  - logic/dd_colmix.sv
  - logic/dd_game.sv
  - target: test
    files:
      - bench/dd_game_checker.sv
      - bench/dd_game_tb.sv
